//--- design/dnc_pkg.sv
//////////////////////////////////////////////////
// DNC usage vector package
// Fixed-point format and the stream payloads
// shared by the usage update pipeline
//////////////////////////////////////////////////

`default_nettype none

package dnc_pkg;

  // Unsigned Q0.16 fraction, all ones stands for 1.0
  localparam int DATA_W = 16;
  localparam int SIZE_W = 16;
  localparam int PROD_W = 2 * DATA_W;

  localparam logic [DATA_W-1:0] ONE_Q = '1;

  // One element of u, w and psi as it enters
  typedef struct packed {
    logic [DATA_W-1:0] u;
    logic [DATA_W-1:0] w;
    logic [DATA_W-1:0] psi;
  } usage_elem_t;

  // Updated usage leaving the block
  typedef struct packed {
    logic [DATA_W-1:0] u;
    logic              last;
  } usage_out_t;

  // Carried next to the u*w product
  typedef struct packed {
    logic [DATA_W-1:0] u;
    logic [DATA_W-1:0] w;
    logic [DATA_W-1:0] psi;
    logic              last;
  } mul1_side_t;

  // Adder operands, p is the truncated u*w
  typedef struct packed {
    logic [DATA_W-1:0] u;
    logic [DATA_W-1:0] w;
    logic [DATA_W-1:0] p;
    logic [DATA_W-1:0] psi;
    logic              last;
  } add_in_t;

  // Only the frame tag rides along with the psi product
  typedef struct packed {
    logic last;
  } mul2_side_t;

endpackage

`default_nettype wire

//--- design/dnc_usage_vector.sv
//////////////////////////////////////////////////
// DNC usage vector update
// u_new = (u + w - u*w) * psi, one element per beat
// Frame control, then multiply, add, multiply
//////////////////////////////////////////////////

`default_nettype none

module dnc_usage_vector (
  input  wire                         CLK,
  input  wire                         RST,

  input  wire                         start_valid,
  output logic                        start_ready,
  input  wire [dnc_pkg::SIZE_W-1:0]   size_n,

  input  wire                         in_valid,
  output logic                        in_ready,
  input  wire dnc_pkg::usage_elem_t   in_elem,

  output logic                        out_valid,
  input  wire                         out_ready,
  output dnc_pkg::usage_out_t         out_elem,
  output logic                        done
);

  // Controller to first multiplier
  logic                        ctrl_valid;
  logic                        m1_ready;
  dnc_pkg::mul1_side_t         ctrl_side;

  // First multiplier to adder
  logic                        m1_valid;
  logic                        add_ready;
  logic [dnc_pkg::DATA_W-1:0]  m1_prod;
  dnc_pkg::mul1_side_t         m1_side;
  dnc_pkg::add_in_t            add_in;

  // Adder to second multiplier
  logic                        add_valid;
  logic                        m2_ready;
  logic [dnc_pkg::DATA_W-1:0]  add_sum;
  logic [dnc_pkg::DATA_W-1:0]  add_psi;
  dnc_pkg::mul2_side_t         add_side;

  // Second multiplier result
  logic [dnc_pkg::DATA_W-1:0]  m2_prod;
  dnc_pkg::mul2_side_t         m2_side;
  logic                        out_handshake;

  assign out_handshake = out_valid & out_ready;

  usage_frame_ctrl i_usage_frame_ctrl (
    .CLK           (CLK),
    .RST           (RST),
    .start_valid   (start_valid),
    .start_ready   (start_ready),
    .size_n        (size_n),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_elem       (in_elem),
    .mul_valid     (ctrl_valid),
    .mul_ready     (m1_ready),
    .mul_side      (ctrl_side),
    .out_handshake (out_handshake),
    .out_last      (out_elem.last),
    .done          (done)
  );

  // u * w
  vector_multiplier #(
    .SIDE_T (dnc_pkg::mul1_side_t)
  ) i_mul_uw (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (ctrl_valid),
    .in_ready  (m1_ready),
    .a         (ctrl_side.u),
    .b         (ctrl_side.w),
    .in_side   (ctrl_side),
    .out_valid (m1_valid),
    .out_ready (add_ready),
    .prod      (m1_prod),
    .out_side  (m1_side)
  );

  assign add_in = '{
    u:    m1_side.u,
    w:    m1_side.w,
    p:    m1_prod,
    psi:  m1_side.psi,
    last: m1_side.last
  };

  usage_adder i_usage_adder (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (m1_valid),
    .in_ready  (add_ready),
    .in_data   (add_in),
    .out_valid (add_valid),
    .out_ready (m2_ready),
    .sum       (add_sum),
    .psi       (add_psi),
    .last      (add_side.last)
  );

  // Retention scaling
  vector_multiplier #(
    .SIDE_T (dnc_pkg::mul2_side_t)
  ) i_mul_psi (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (add_valid),
    .in_ready  (m2_ready),
    .a         (add_sum),
    .b         (add_psi),
    .in_side   (add_side),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .prod      (m2_prod),
    .out_side  (m2_side)
  );

  assign out_elem = '{
    u:    m2_prod,
    last: m2_side.last
  };

endmodule

`default_nettype wire

//--- design/usage_adder.sv
//////////////////////////////////////////////////
// Usage adder
// sum = u + w - p, clamped to one
// psi and last pass through in the same stage
//////////////////////////////////////////////////

`default_nettype none

module usage_adder (
  input  wire                         CLK,
  input  wire                         RST,

  input  wire                         in_valid,
  output logic                        in_ready,
  input  wire dnc_pkg::add_in_t       in_data,

  output logic                        out_valid,
  input  wire                         out_ready,
  output logic [dnc_pkg::DATA_W-1:0]  sum,
  output logic [dnc_pkg::DATA_W-1:0]  psi,
  output logic                        last
);

  // One guard bit for the carry of u + w
  logic [dnc_pkg::DATA_W:0]    raw_sum;
  logic [dnc_pkg::DATA_W-1:0]  clamped;

  // p = u*w >> 16 never exceeds u or w, so no wrap below zero
  assign raw_sum = {1'b0, in_data.u} + {1'b0, in_data.w} - {1'b0, in_data.p};

  // Carry out means above one
  assign clamped = raw_sum[dnc_pkg::DATA_W] ? dnc_pkg::ONE_Q
                                             : raw_sum[dnc_pkg::DATA_W-1:0];

  assign in_ready = ~out_valid | out_ready;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // Result register with its sideband
  always_ff @(posedge CLK) begin
    if (in_valid && in_ready) begin
      sum  <= clamped;
      psi  <= in_data.psi;
      last <= in_data.last;
    end
  end

endmodule

`default_nettype wire

//--- design/usage_frame_ctrl.sv
//////////////////////////////////////////////////
// Usage frame controller
// Takes a start with N, passes N elements to the
// pipeline, tags the last one, then waits for it
// at the output and pulses done
//////////////////////////////////////////////////

`default_nettype none

module usage_frame_ctrl (
  input  wire                         CLK,
  input  wire                         RST,

  // Start command
  input  wire                         start_valid,
  output logic                        start_ready,
  input  wire [dnc_pkg::SIZE_W-1:0]   size_n,

  // Element stream from outside
  input  wire                         in_valid,
  output logic                        in_ready,
  input  wire dnc_pkg::usage_elem_t   in_elem,

  // Towards the first multiplier
  output logic                        mul_valid,
  input  wire                         mul_ready,
  output dnc_pkg::mul1_side_t         mul_side,

  // Output side observation
  input  wire                         out_handshake,
  input  wire                         out_last,
  output logic                        done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STREAM,
    ST_DRAIN
  } state_t;

  state_t                      state;
  logic [dnc_pkg::SIZE_W-1:0]  size_q;
  logic [dnc_pkg::SIZE_W-1:0]  elem_cnt;
  logic                        streaming;
  logic                        in_fire;
  logic                        last_elem;

  //////////////////////////////////////////////////
  // Stream gating
  //////////////////////////////////////////////////

  assign streaming   = (state == ST_STREAM);
  assign start_ready = (state == ST_IDLE);

  // Elements only flow while the frame still expects some
  assign in_ready  = streaming & mul_ready;
  assign mul_valid = streaming & in_valid;
  assign in_fire   = mul_valid & mul_ready;

  // Count is zero based, element N sits at N-1
  assign last_elem = (elem_cnt == size_q - dnc_pkg::SIZE_W'(1));

  assign mul_side = '{
    u:    in_elem.u,
    w:    in_elem.w,
    psi:  in_elem.psi,
    last: last_elem
  };

  //////////////////////////////////////////////////
  // Frame FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= ST_IDLE;
      size_q   <= '0;
      elem_cnt <= '0;
      done     <= 1'b0;
    end else begin
      // Single cycle pulse by default
      done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start_valid) begin
            size_q   <= size_n;
            elem_cnt <= '0;
            state    <= ST_STREAM;
          end
        end
        ST_STREAM: begin
          if (in_fire) begin
            if (last_elem) begin
              state <= ST_DRAIN;
            end else begin
              elem_cnt <= elem_cnt + dnc_pkg::SIZE_W'(1);
            end
          end
        end
        ST_DRAIN: begin
          // Tagged beat leaving means the frame is complete
          if (out_handshake && out_last) begin
            state <= ST_IDLE;
            done  <= 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/vector_multiplier.sv
//////////////////////////////////////////////////
// Fixed-point element multiplier
// prod = (a * b) >> DATA_W, truncated
// Valid/ready stream, sideband of any packed type
//////////////////////////////////////////////////

`default_nettype none

module vector_multiplier #(
  parameter type SIDE_T = logic
) (
  input  wire                         CLK,
  input  wire                         RST,

  // Operand stream
  input  wire                         in_valid,
  output logic                        in_ready,
  input  wire [dnc_pkg::DATA_W-1:0]   a,
  input  wire [dnc_pkg::DATA_W-1:0]   b,
  input  wire SIDE_T                  in_side,

  // Product stream
  output logic                        out_valid,
  input  wire                         out_ready,
  output logic [dnc_pkg::DATA_W-1:0]  prod,
  output SIDE_T                       out_side
);

  //////////////////////////////////////////////////
  // Stage one, full-width product register
  //////////////////////////////////////////////////

  logic                        s1_valid;
  logic [dnc_pkg::PROD_W-1:0]  s1_prod;
  SIDE_T                       s1_side;

  // Free slot, or the held item leaves this edge
  assign in_ready = ~s1_valid | out_ready;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
    end else if (in_ready) begin
      s1_valid <= in_valid;
    end
  end

  // Payload only loads on a transfer, held while stalled
  always_ff @(posedge CLK) begin
    if (in_valid && in_ready) begin
      s1_prod <= dnc_pkg::PROD_W'(a) * dnc_pkg::PROD_W'(b);
      s1_side <= in_side;
    end
  end

  //////////////////////////////////////////////////
  // Stage two, back to Q0.16
  //////////////////////////////////////////////////

  // Drop the low fraction bits, no rounding
  assign prod      = dnc_pkg::DATA_W'(s1_prod >> dnc_pkg::DATA_W);
  assign out_side  = s1_side;
  assign out_valid = s1_valid;

endmodule

`default_nettype wire

//--- dv/tb_dnc_usage_vector.sv
//////////////////////////////////////////////////
// DNC usage vector testbench
// Directed frames against a fixed-point reference
// with corner values, random data, back-pressure
// and start/input gating
//////////////////////////////////////////////////

`default_nettype none

module tb_dnc_usage_vector;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 500;
  localparam int MAX_N   = 64;

  logic                          CLK;
  logic                          RST;
  logic                          start_valid;
  logic                          start_ready;
  logic [dnc_pkg::SIZE_W-1:0]    size_n;
  logic                          in_valid;
  logic                          in_ready;
  dnc_pkg::usage_elem_t          in_elem;
  logic                          out_valid;
  logic                          out_ready;
  dnc_pkg::usage_out_t           out_elem;
  logic                          done;

  int                            errors = 0;
  int                            cyc = 0;
  logic [31:0]                   rng_state = 32'd36182;

  // Current frame data, expected results and input edges
  dnc_pkg::usage_elem_t          elems [0:MAX_N-1];
  logic [dnc_pkg::DATA_W-1:0]    exp_u [0:MAX_N-1];
  int                            acc_edge [0:MAX_N-1];

  dnc_usage_vector i_dnc_usage_vector (
    .CLK         (CLK),
    .RST         (RST),
    .start_valid (start_valid),
    .start_ready (start_ready),
    .size_n      (size_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_elem     (in_elem),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_elem    (out_elem),
    .done        (done)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Edge counter read at the falling edge
  always @(posedge CLK) cyc <= cyc + 1;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // (u + w - u*w) * psi in Q0.16 with truncated products and the sum clamped to one
  function automatic logic [15:0] ref_usage(input logic [15:0] u, input logic [15:0] w,
                                            input logic [15:0] psi);
    logic [31:0] uw_full;
    logic [16:0] raw;
    logic [15:0] keep;
    logic [31:0] ret_full;
    uw_full = {16'd0, u} * {16'd0, w};
    raw = {1'b0, u} + {1'b0, w} - {1'b0, uw_full[31:16]};
    if (raw > 17'h0FFFF) begin
      keep = dnc_pkg::ONE_Q;
    end else begin
      keep = raw[15:0];
    end
    ret_full = {16'd0, keep} * {16'd0, psi};
    return ret_full[31:16];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %0t ns %s: expected %0h, got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_no_timeout(input logic ok, input string what);
    assert (ok) else begin
      $display("Timeout at %0t ns while waiting for %s", $time, what);
      errors++;
    end
  endtask

  task automatic compute_expected(input int n);
    for (int i = 0; i < n; i++) begin
      exp_u[i] = ref_usage(elems[i].u, elems[i].w, elems[i].psi);
    end
  endtask

  task automatic fill_random(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = xorshift();
      elems[i].u = r[15:0];
      elems[i].w = r[31:16];
      r = xorshift();
      elems[i].psi = r[15:0];
    end
    compute_expected(n);
  endtask

  // Called and left 1 ns after a rising edge
  task automatic start_frame(input int n);
    logic ok;
    int   t;
    ok = 1'b0;
    t = 0;
    start_valid = 1'b1;
    size_n = dnc_pkg::SIZE_W'(n);
    while (!ok && t < TIMEOUT) begin
      @(negedge CLK);
      ok = start_ready;
      @(posedge CLK);
      #1;
      t++;
    end
    check_no_timeout(ok, "start_ready");
    start_valid = 1'b0;
  endtask

  task automatic drive_elements(input int n);
    logic ok;
    int   t;
    for (int i = 0; i < n; i++) begin
      in_valid = 1'b1;
      in_elem = elems[i];
      ok = 1'b0;
      t = 0;
      while (!ok && t < TIMEOUT) begin
        @(negedge CLK);
        ok = in_ready;
        // Transfer happens on the coming edge
        if (ok) acc_edge[i] = cyc + 1;
        @(posedge CLK);
        #1;
        t++;
      end
      check_no_timeout(ok, "in_ready");
    end
    in_valid = 1'b0;
  endtask

  task automatic collect_outputs(input int n, input logic backpressure,
                                 input logic check_latency);
    int                   i;
    int                   t;
    logic [31:0]          r;
    logic                 held;
    dnc_pkg::usage_out_t  held_elem;
    i = 0;
    t = 0;
    held = 1'b0;
    while (i < n && t < TIMEOUT) begin
      if (backpressure) begin
        r = xorshift();
        out_ready = r[0];
      end else begin
        out_ready = 1'b1;
      end
      @(negedge CLK);
      // Stalled beat must stay put
      if (held) begin
        check_value("out_valid (stalled)", 32'(out_valid), 32'd1);
        check_value("out_elem (stalled)", 32'(out_elem), 32'(held_elem));
      end
      check_value("done", 32'(done), 32'd0);
      held = out_valid && !out_ready;
      held_elem = out_elem;
      if (out_valid && out_ready) begin
        check_value("out_elem.u", 32'(out_elem.u), 32'(exp_u[i]));
        check_value("out_elem.last", 32'(out_elem.last), 32'(i == n - 1));
        if (check_latency) begin
          check_value("latency", 32'(cyc + 1 - acc_edge[i]), 32'd3);
        end
        i++;
      end
      @(posedge CLK);
      #1;
      t++;
    end
    check_no_timeout(i == n, "the output beats");
    out_ready = 1'b1;
    // One cycle after the last take
    @(negedge CLK);
    check_value("done", 32'(done), 32'd1);
    check_value("out_valid", 32'(out_valid), 32'd0);
    @(negedge CLK);
    check_value("done", 32'(done), 32'd0);
  endtask

  task automatic run_frame(input int n, input logic backpressure, input logic check_latency);
    start_frame(n);
    fork
      drive_elements(n);
      collect_outputs(n, backpressure, check_latency);
    join
    @(posedge CLK);
    #1;
  endtask

  // Start waits while busy and no element slips past N
  task automatic hold_start_while_busy(input int n, input int next_n);
    int   accepted;
    int   taken;
    int   t;
    logic last_taken;
    logic idle_again;
    accepted = 0;
    taken = 0;
    t = 0;
    last_taken = 1'b0;
    idle_again = 1'b0;
    start_valid = 1'b1;
    size_n = dnc_pkg::SIZE_W'(next_n);
    while (!idle_again && t < TIMEOUT) begin
      @(negedge CLK);
      if (accepted >= n) check_value("in_ready", 32'(in_ready), 32'd0);
      // Idle again one cycle after the frame's last beat leaves
      check_value("start_ready", 32'(start_ready), 32'(last_taken));
      idle_again = last_taken;
      if (in_valid && in_ready) accepted++;
      if (out_valid && out_ready) taken++;
      last_taken = (taken == n);
      @(posedge CLK);
      #1;
      t++;
    end
    check_no_timeout(idle_again, "the frame to finish");
    start_valid = 1'b0;
  endtask

  task automatic report_and_finish();
    $display("Error count: %0d", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_reset_values();
    @(negedge CLK);
    check_value("start_ready", 32'(start_ready), 32'd1);
    check_value("in_ready", 32'(in_ready), 32'd0);
    check_value("out_valid", 32'(out_valid), 32'd0);
    check_value("done", 32'(done), 32'd0);
    @(posedge CLK);
    #1;
  endtask

  task automatic test_corner_values();
    // u zero, w one, psi one, then everything at one for the clamp
    elems[0] = '{u: 16'h0000, w: 16'h1234, psi: 16'hABCD};
    elems[1] = '{u: 16'h4321, w: dnc_pkg::ONE_Q, psi: 16'h8000};
    elems[2] = '{u: 16'h9000, w: 16'h7000, psi: dnc_pkg::ONE_Q};
    elems[3] = '{u: dnc_pkg::ONE_Q, w: dnc_pkg::ONE_Q, psi: dnc_pkg::ONE_Q};
    compute_expected(4);
    run_frame(4, 1'b0, 1'b1);
  endtask

  task automatic test_random_frame();
    fill_random(32);
    run_frame(32, 1'b0, 1'b0);
  endtask

  task automatic test_backpressure();
    fill_random(20);
    run_frame(20, 1'b1, 1'b0);
  endtask

  task automatic test_input_gating();
    fill_random(6);
    start_frame(6);
    fork
      drive_elements(6);
      collect_outputs(6, 1'b0, 1'b0);
      hold_start_while_busy(6, 5);
    join
    // Start for the second frame was taken right after done
    fill_random(5);
    @(posedge CLK);
    #1;
    fork
      drive_elements(5);
      collect_outputs(5, 1'b1, 1'b0);
    join
  endtask

  initial begin
    RST = 1'b1;
    start_valid = 1'b0;
    size_n = '0;
    in_valid = 1'b0;
    in_elem = '0;
    out_ready = 1'b0;
    repeat (8) @(posedge CLK);
    #1;
    RST = 1'b0;
    test_reset_values();
    test_corner_values();
    test_random_frame();
    test_backpressure();
    test_input_gating();
    report_and_finish();
  end

  // Whole-run limit
  initial begin
    #100000;
    $display("Simulation did not finish within the time limit");
    errors++;
    report_and_finish();
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the DNC usage vector testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dnc_usage_vector -f sim.f -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -qx "All checks passed" sim.log \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED, see sim.log"; exit 1; }

//--- sim.f
design/dnc_pkg.sv
design/vector_multiplier.sv
design/usage_adder.sv
design/usage_frame_ctrl.sv
design/dnc_usage_vector.sv
dv/tb_dnc_usage_vector.sv
